/* src/tetrisPkg.sv */
package tetrisPkg;

	// grid geometry, row 0 is the top
	localparam int numRows = 22;
	localparam int numCols = 11;
	localparam int rowIdxW = 5;
	localparam int colIdxW = 4;

	localparam int scoreW = 16;
	localparam int cellsPerPiece = 4;

	// colour codes as the display expects them
	typedef enum logic [3:0] {
		colEmpty = 4'd0,
		colI     = 4'd1,
		colO     = 4'd2,
		colZ     = 4'd3,
		colL     = 4'd4,
		colS     = 4'd5,
		colJ     = 4'd6,
		colT     = 4'd7
	} cellColorT;

	// one code per piece orientation
	typedef enum logic [4:0] {
		shO,
		shIHoriz,
		shIVert,
		shZHoriz,
		shZVert,
		shSHoriz,
		shSVert,
		shJUp,
		shJDown,
		shJLeft,
		shJRight,
		shLUp,
		shLDown,
		shLLeft,
		shLRight,
		shTUp,
		shTDown,
		shTLeft,
		shTRight
	} pieceShapeT;

	typedef struct packed {
		logic [rowIdxW-1:0] row;
		logic [colIdxW-1:0] col;
	} cellPosT;

	typedef struct packed {
		pieceShapeT shape;
		cellPosT    anchor;
	} lockReqT;

	typedef struct packed {
		cellColorT                    color;
		cellPosT [cellsPerPiece-1:0] cells;
	} stampT;

	typedef cellColorT [numCols-1:0] rowT;
	typedef rowT [numRows-1:0] boardT;

endpackage

/* src/pieceStamper.sv */
`timescale 1ns/1ns

module pieceStamper (
	input  tetrisPkg::lockReqT lockReq,
	output tetrisPkg::stampT   stamp
);

	logic [1:0] dRow [tetrisPkg::cellsPerPiece];
	logic [1:0] dCol [tetrisPkg::cellsPerPiece];
	tetrisPkg::cellColorT color;

	// offsets relative to the anchor, as (row, col) per cell
	always_comb begin
		dRow = '{2'd0, 2'd0, 2'd0, 2'd0};
		dCol = '{2'd0, 2'd0, 2'd0, 2'd0};
		color = tetrisPkg::colEmpty;
		case (lockReq.shape)
			tetrisPkg::shO: begin
				color = tetrisPkg::colO;
				dRow = '{2'd0, 2'd1, 2'd0, 2'd1};
				dCol = '{2'd0, 2'd0, 2'd1, 2'd1};
			end
			tetrisPkg::shIHoriz: begin
				color = tetrisPkg::colI;
				dCol = '{2'd0, 2'd1, 2'd2, 2'd3};
			end
			tetrisPkg::shIVert: begin
				color = tetrisPkg::colI;
				dRow = '{2'd0, 2'd1, 2'd2, 2'd3};
			end
			tetrisPkg::shZHoriz: begin
				color = tetrisPkg::colZ;
				dRow = '{2'd0, 2'd0, 2'd1, 2'd1};
				dCol = '{2'd0, 2'd1, 2'd1, 2'd2};
			end
			tetrisPkg::shZVert: begin
				color = tetrisPkg::colZ;
				dRow = '{2'd0, 2'd1, 2'd1, 2'd2};
				dCol = '{2'd1, 2'd0, 2'd1, 2'd0};
			end
			tetrisPkg::shSHoriz: begin
				color = tetrisPkg::colS;
				dRow = '{2'd0, 2'd0, 2'd1, 2'd1};
				dCol = '{2'd1, 2'd2, 2'd0, 2'd1};
			end
			tetrisPkg::shSVert: begin
				color = tetrisPkg::colS;
				dRow = '{2'd0, 2'd1, 2'd1, 2'd2};
				dCol = '{2'd0, 2'd0, 2'd1, 2'd1};
			end
			tetrisPkg::shJUp: begin
				color = tetrisPkg::colJ;
				dRow = '{2'd0, 2'd1, 2'd2, 2'd2};
				dCol = '{2'd1, 2'd1, 2'd1, 2'd0};
			end
			tetrisPkg::shJDown: begin
				color = tetrisPkg::colJ;
				dRow = '{2'd0, 2'd0, 2'd1, 2'd2};
				dCol = '{2'd0, 2'd1, 2'd0, 2'd0};
			end
			tetrisPkg::shJLeft: begin
				color = tetrisPkg::colJ;
				dRow = '{2'd0, 2'd0, 2'd0, 2'd1};
				dCol = '{2'd0, 2'd1, 2'd2, 2'd2};
			end
			tetrisPkg::shJRight: begin
				color = tetrisPkg::colJ;
				dRow = '{2'd0, 2'd1, 2'd1, 2'd1};
				dCol = '{2'd0, 2'd0, 2'd1, 2'd2};
			end
			tetrisPkg::shLUp: begin
				color = tetrisPkg::colL;
				dRow = '{2'd0, 2'd1, 2'd2, 2'd2};
				dCol = '{2'd0, 2'd0, 2'd0, 2'd1};
			end
			tetrisPkg::shLDown: begin
				color = tetrisPkg::colL;
				dRow = '{2'd0, 2'd0, 2'd1, 2'd2};
				dCol = '{2'd0, 2'd1, 2'd1, 2'd1};
			end
			tetrisPkg::shLLeft: begin
				color = tetrisPkg::colL;
				dRow = '{2'd1, 2'd1, 2'd1, 2'd0};
				dCol = '{2'd0, 2'd1, 2'd2, 2'd2};
			end
			tetrisPkg::shLRight: begin
				color = tetrisPkg::colL;
				dRow = '{2'd0, 2'd0, 2'd0, 2'd1};
				dCol = '{2'd0, 2'd1, 2'd2, 2'd0};
			end
			tetrisPkg::shTUp: begin
				color = tetrisPkg::colT;
				dRow = '{2'd0, 2'd1, 2'd1, 2'd1};
				dCol = '{2'd1, 2'd0, 2'd1, 2'd2};
			end
			tetrisPkg::shTDown: begin
				color = tetrisPkg::colT;
				dRow = '{2'd0, 2'd0, 2'd0, 2'd1};
				dCol = '{2'd0, 2'd1, 2'd2, 2'd1};
			end
			tetrisPkg::shTLeft: begin
				color = tetrisPkg::colT;
				dRow = '{2'd0, 2'd1, 2'd1, 2'd2};
				dCol = '{2'd1, 2'd0, 2'd1, 2'd1};
			end
			tetrisPkg::shTRight: begin
				color = tetrisPkg::colT;
				dRow = '{2'd0, 2'd1, 2'd2, 2'd1};
				dCol = '{2'd0, 2'd0, 2'd0, 2'd1};
			end
			default: ;
		endcase
	end

	// a sum that wraps saturates instead, so it stays outside the grid
	always_comb begin
		logic [tetrisPkg::rowIdxW:0] rowSum;
		logic [tetrisPkg::colIdxW:0] colSum;
		stamp.color = color;
		for (int i = 0; i < tetrisPkg::cellsPerPiece; i++) begin
			rowSum = {1'b0, lockReq.anchor.row} + (tetrisPkg::rowIdxW + 1)'(dRow[i]);
			colSum = {1'b0, lockReq.anchor.col} + (tetrisPkg::colIdxW + 1)'(dCol[i]);
			stamp.cells[i].row = rowSum[tetrisPkg::rowIdxW] ? '1 : rowSum[tetrisPkg::rowIdxW-1:0];
			stamp.cells[i].col = colSum[tetrisPkg::colIdxW] ? '1 : colSum[tetrisPkg::colIdxW-1:0];
		end
	end

endmodule

/* src/fullRowFinder.sv */
`timescale 1ns/1ns

module fullRowFinder (
	input  tetrisPkg::boardT              board,
	output logic                          rowFull,
	output logic [tetrisPkg::rowIdxW-1:0] fullRow
);

	logic [tetrisPkg::numRows-1:0] rowIsFull;

	// a row is full when no cell holds the empty code
	always_comb begin
		for (int r = 0; r < tetrisPkg::numRows; r++) begin
			rowIsFull[r] = 1'b1;
			for (int c = 0; c < tetrisPkg::numCols; c++) begin
				if (board[r][c] == tetrisPkg::colEmpty) begin
					rowIsFull[r] = 1'b0;
				end
			end
		end
	end

	// bottom row first, the first hit is the lowest
	always_comb begin
		rowFull = 1'b0;
		fullRow = '0;
		for (int r = tetrisPkg::numRows - 1; r >= 0; r--) begin
			if (rowIsFull[r] && !rowFull) begin
				rowFull = 1'b1;
				fullRow = tetrisPkg::rowIdxW'(r);
			end
		end
	end

endmodule

/* src/playfield.sv */
`timescale 1ns/1ns

module playfield (
	input  logic                          Clk,
	input  logic                          rst,
	input  logic                          lock,
	input  tetrisPkg::stampT              stamp,
	input  logic                          rowFull,
	input  logic [tetrisPkg::rowIdxW-1:0] fullRow,
	output tetrisPkg::boardT              board,
	output logic [tetrisPkg::scoreW-1:0]  score
);

	logic [tetrisPkg::cellsPerPiece-1:0] cellInGrid;

	// cells past the bottom or right edge are dropped
	always_comb begin
		for (int i = 0; i < tetrisPkg::cellsPerPiece; i++) begin
			cellInGrid[i] = (stamp.cells[i].row < tetrisPkg::rowIdxW'(tetrisPkg::numRows)) &&
				(stamp.cells[i].col < tetrisPkg::colIdxW'(tetrisPkg::numCols)) &&
				(stamp.color != tetrisPkg::colEmpty);
		end
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			board <= tetrisPkg::boardT'('0);
			score <= '0;
		end else if (lock) begin
			// a landing piece wins, clearing waits a cycle
			for (int i = 0; i < tetrisPkg::cellsPerPiece; i++) begin
				if (cellInGrid[i]) begin
					board[stamp.cells[i].row][stamp.cells[i].col] <= stamp.color;
				end
			end
		end else if (rowFull) begin
			// rows above the full one drop by one
			for (int r = 1; r < tetrisPkg::numRows; r++) begin
				if (tetrisPkg::rowIdxW'(r) <= fullRow) begin
					board[r] <= board[r-1];
				end
			end
			board[0] <= tetrisPkg::rowT'('0);
			score <= score + 1'b1;
		end
	end

endmodule

/* src/tetrisBoard.sv */
`timescale 1ns/1ns

module tetrisBoard (
	input  logic                         Clk,
	input  logic                         rst,
	input  logic                         lock,
	input  tetrisPkg::lockReqT           lockReq,
	output tetrisPkg::boardT             board,
	output logic [tetrisPkg::scoreW-1:0] score
);

	tetrisPkg::stampT stamp;
	logic rowFull;
	logic [tetrisPkg::rowIdxW-1:0] fullRow;

	pieceStamper stamper0 (
		.lockReq (lockReq),
		.stamp   (stamp)
	);

	// looks at the registered grid, so a clear follows the lock that filled it
	fullRowFinder finder0 (
		.board   (board),
		.rowFull (rowFull),
		.fullRow (fullRow)
	);

	playfield field0 (
		.Clk     (Clk),
		.rst     (rst),
		.lock    (lock),
		.stamp   (stamp),
		.rowFull (rowFull),
		.fullRow (fullRow),
		.board   (board),
		.score   (score)
	);

endmodule

/* sim/tbTetrisBoard.sv */
`timescale 1ns/1ns

module tbTetrisBoard;

	typedef struct {
		string                 name;
		tetrisPkg::pieceShapeT shape;
		int                    row;
		int                    col;
		bit                    lockBeforeCheck;
		int                    expScore;
	} stimT;

	logic Clk;
	logic rst;
	logic lock;
	tetrisPkg::lockReqT lockReq;
	tetrisPkg::boardT board;
	logic [tetrisPkg::scoreW-1:0] score;

	tetrisPkg::boardT modelBoard;
	int modelScore;
	int errors;
	int seed;
	stimT stimTable[$];

	tetrisBoard dut0 (
		.Clk     (Clk),
		.rst     (rst),
		.lock    (lock),
		.lockReq (lockReq),
		.board   (board),
		.score   (score)
	);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	// four (row, col) pairs as hex digits, cell 0 first
	function automatic logic [31:0] shapeOffsets(tetrisPkg::pieceShapeT shape);
		case (shape)
			tetrisPkg::shO:      return 32'h0010_0111;
			tetrisPkg::shIHoriz: return 32'h0001_0203;
			tetrisPkg::shIVert:  return 32'h0010_2030;
			tetrisPkg::shZHoriz: return 32'h0001_1112;
			tetrisPkg::shZVert:  return 32'h0110_1120;
			tetrisPkg::shSHoriz: return 32'h0102_1011;
			tetrisPkg::shSVert:  return 32'h0010_1121;
			tetrisPkg::shJUp:    return 32'h0111_2120;
			tetrisPkg::shJDown:  return 32'h0001_1020;
			tetrisPkg::shJLeft:  return 32'h0001_0212;
			tetrisPkg::shJRight: return 32'h0010_1112;
			tetrisPkg::shLUp:    return 32'h0010_2021;
			tetrisPkg::shLDown:  return 32'h0001_1121;
			tetrisPkg::shLLeft:  return 32'h1011_1202;
			tetrisPkg::shLRight: return 32'h0001_0210;
			tetrisPkg::shTUp:    return 32'h0110_1112;
			tetrisPkg::shTDown:  return 32'h0001_0211;
			tetrisPkg::shTLeft:  return 32'h0110_1121;
			tetrisPkg::shTRight: return 32'h0010_2011;
			default:             return 32'h0;
		endcase
	endfunction

	function automatic tetrisPkg::cellColorT shapeColor(tetrisPkg::pieceShapeT shape);
		case (shape)
			tetrisPkg::shO: return tetrisPkg::colO;
			tetrisPkg::shIHoriz, tetrisPkg::shIVert: return tetrisPkg::colI;
			tetrisPkg::shZHoriz, tetrisPkg::shZVert: return tetrisPkg::colZ;
			tetrisPkg::shSHoriz, tetrisPkg::shSVert: return tetrisPkg::colS;
			tetrisPkg::shJUp, tetrisPkg::shJDown,
			tetrisPkg::shJLeft, tetrisPkg::shJRight: return tetrisPkg::colJ;
			tetrisPkg::shLUp, tetrisPkg::shLDown,
			tetrisPkg::shLLeft, tetrisPkg::shLRight: return tetrisPkg::colL;
			default: return tetrisPkg::colT;
		endcase
	endfunction

	task automatic modelLock(tetrisPkg::pieceShapeT shape, int row, int col);
		logic [31:0] offs;
		int r;
		int c;
		offs = shapeOffsets(shape);
		for (int i = 0; i < tetrisPkg::cellsPerPiece; i++) begin
			r = row + int'(offs[31-8*i -: 4]);
			c = col + int'(offs[27-8*i -: 4]);
			// off-grid cells are simply lost
			if (r < tetrisPkg::numRows && c < tetrisPkg::numCols) begin
				modelBoard[r][c] = shapeColor(shape);
			end
		end
	endtask

	function automatic int lowestFullRow();
		bit full;
		for (int r = tetrisPkg::numRows - 1; r >= 0; r--) begin
			full = 1'b1;
			for (int c = 0; c < tetrisPkg::numCols; c++) begin
				if (modelBoard[r][c] == tetrisPkg::colEmpty) begin
					full = 1'b0;
				end
			end
			if (full) begin
				return r;
			end
		end
		return -1;
	endfunction

	task automatic modelClearRows();
		int fr;
		fr = lowestFullRow();
		while (fr >= 0) begin
			for (int r = fr; r > 0; r--) begin
				modelBoard[r] = modelBoard[r-1];
			end
			modelBoard[0] = tetrisPkg::rowT'('0);
			modelScore++;
			fr = lowestFullRow();
		end
	endtask

	task automatic checkEqual(string name, logic [63:0] expected, logic [63:0] actual);
		if (expected !== actual) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic compareBoard(string name);
		for (int r = 0; r < tetrisPkg::numRows; r++) begin
			checkEqual($sformatf("%s row %0d", name, r), 64'(modelBoard[r]), 64'(board[r]));
		end
		checkEqual({name, " score"}, 64'(modelScore[15:0]), 64'(score));
	endtask

	task automatic resetDut();
		@(negedge Clk);
		rst = 1'b1;
		lock = 1'b0;
		repeat (3) @(negedge Clk);
		rst = 1'b0;
		modelBoard = tetrisPkg::boardT'('0);
		modelScore = 0;
	endtask

	task automatic driveLock(tetrisPkg::pieceShapeT shape, int row, int col);
		@(negedge Clk);
		lock = 1'b1;
		lockReq.shape = shape;
		lockReq.anchor.row = tetrisPkg::rowIdxW'(row);
		lockReq.anchor.col = tetrisPkg::colIdxW'(col);
	endtask

	// drop the strobe, let the clears run out, then compare
	task automatic finishGroup(string name, int expScore);
		int cycles;
		@(negedge Clk);
		lock = 1'b0;
		// one cycle after the last strobe the cells are in, no clear yet
		compareBoard({name, " lock"});
		modelClearRows();
		cycles = 0;
		while (int'(score) != expScore && cycles < 50) begin
			@(negedge Clk);
			cycles++;
		end
		if (int'(score) != expScore) begin
			$display("timeout: score never reached %0d in %s", expScore, name);
			errors++;
		end
		@(negedge Clk);
		checkEqual({name, " table score"}, 64'(expScore), 64'(modelScore));
		compareBoard(name);
	endtask

	task automatic addStim(string name, tetrisPkg::pieceShapeT shape, int row, int col,
		bit lockBeforeCheck, int expScore);
		stimT s;
		s.name = name;
		s.shape = shape;
		s.row = row;
		s.col = col;
		s.lockBeforeCheck = lockBeforeCheck;
		s.expScore = expScore;
		stimTable.push_back(s);
	endtask

	// locks in a group go out on consecutive cycles, the last one checks
	task automatic buildTable();
		addStim("clip tDown", tetrisPkg::shTDown, 21, 8, 1'b1, 0);
		addStim("clip iHoriz", tetrisPkg::shIHoriz, 10, 9, 1'b1, 0);
		addStim("one row a", tetrisPkg::shIHoriz, 21, 0, 1'b0, 0);
		addStim("one row b", tetrisPkg::shIHoriz, 21, 4, 1'b0, 0);
		addStim("one row", tetrisPkg::shTDown, 21, 8, 1'b1, 1);
		addStim("two rows a", tetrisPkg::shIHoriz, 21, 0, 1'b0, 0);
		addStim("two rows b", tetrisPkg::shIHoriz, 21, 4, 1'b0, 0);
		addStim("two rows c", tetrisPkg::shIHoriz, 20, 0, 1'b0, 0);
		addStim("two rows d", tetrisPkg::shIHoriz, 20, 4, 1'b0, 0);
		addStim("two rows e", tetrisPkg::shO, 20, 8, 1'b0, 0);
		addStim("two rows", tetrisPkg::shIVert, 19, 10, 1'b1, 2);
		addStim("priority a", tetrisPkg::shIHoriz, 21, 0, 1'b0, 0);
		addStim("priority b", tetrisPkg::shIHoriz, 21, 4, 1'b0, 0);
		addStim("priority c", tetrisPkg::shTDown, 21, 8, 1'b0, 0);
		addStim("priority", tetrisPkg::shO, 18, 3, 1'b1, 1);
	endtask

	initial begin
		stimT s;
		tetrisPkg::pieceShapeT shp;
		int row;
		int col;
		errors = 0;
		seed = 32'h57f7_224d;
		rst = 1'b1;
		lock = 1'b0;
		lockReq = '0;
		buildTable();

		resetDut();
		@(negedge Clk);
		compareBoard("reset");

		// every orientation alone on an empty board
		for (int sh = 0; sh < 19; sh++) begin
			shp = tetrisPkg::pieceShapeT'(sh);
			row = {$random(seed)} % tetrisPkg::numRows;
			col = {$random(seed)} % tetrisPkg::numCols;
			resetDut();
			driveLock(shp, row, col);
			modelLock(shp, row, col);
			finishGroup($sformatf("stamp %s", shp.name()), 0);
		end

		resetDut();
		foreach (stimTable[i]) begin
			s = stimTable[i];
			driveLock(s.shape, s.row, s.col);
			modelLock(s.shape, s.row, s.col);
			if (s.lockBeforeCheck) begin
				finishGroup(s.name, s.expScore);
				resetDut();
			end
		end

		$display("%0d errors", errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* files.f */
src/tetrisPkg.sv
src/pieceStamper.sv
src/fullRowFinder.sv
src/playfield.sv
src/tetrisBoard.sv
sim/tbTetrisBoard.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tbTetrisBoard
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(BUILD)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
